// ==== sources.f ====
+incdir+verilog
verilog/adc_trig_pkg.sv
verilog/base_calc.sv
verilog/trigger_detect.sv
verilog/exec_state_ctrl.sv
verilog/adc_trig_top.sv
dv/adc_trig_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module adc_trig_tb -o adc_trig_sim
	@out="$$(./obj_dir/adc_trig_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== dv/adc_trig_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_trig_config.svh"

module adc_trig_tb
    import adc_trig_pkg::*;
();

    localparam int LANES      = `SAMPLES_PER_BEAT;
    localparam int CALC_LEN   = `BASELINE_CALC_LEN;
    localparam int MARGIN     = `THRESHOLD_CODES;
    localparam int WAIT_LIMIT = 200;
    localparam int SIG_DONE   = 0;
    localparam int SIG_STATE  = 1;
    localparam int SIG_REQ    = 2;

    logic                                    AXIS_ACLK = 1'b0;
    logic                                    AXIS_ARESETN;
    logic [`S_AXIS_TDATA_WIDTH-1:0]          s_axis_tdata;
    logic                                    s_axis_tvalid;
    logic                                    rebase;
    logic                                    event_ack;
    logic signed [`ADC_RESOLUTION_WIDTH-1:0] baseline;
    logic                                    calc_complete;
    exec_state_t                             exec_state;
    logic                                    event_req;
    logic [31:0]                             event_beat;
    logic signed [`ADC_RESOLUTION_WIDTH-1:0] event_peak;
    logic [$clog2(`SAMPLES_PER_BEAT)-1:0]    event_lane;

    logic [31:0] lfsr;
    int          cycle = 0;
    int          lane_val [LANES];
    int          level;
    int          exp_base;
    int          scan_idx;
    int          events_sent;
    int          events_seen;
    int          hold_beat;
    int          hold_peak;
    int          hold_lane;
    logic        req_q;
    logic        ack_q;

    // beats taken for the baseline and beats sent since arming
    logic [`S_AXIS_TDATA_WIDTH-1:0] init_beats [$];
    logic [`S_AXIS_TDATA_WIDTH-1:0] arm_data [$];
    int                             arm_cyc [$];
    bit                             arm_pend [$];

    adc_trig_top DUT (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .rebase        (rebase),
        .event_ack     (event_ack),
        .baseline      (baseline),
        .calc_complete (calc_complete),
        .exec_state    (exec_state),
        .event_req     (event_req),
        .event_beat    (event_beat),
        .event_peak    (event_peak),
        .event_lane    (event_lane)
    );

    always #50 AXIS_ACLK = ~AXIS_ACLK;

    always @(posedge AXIS_ACLK)
    begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input int got, input int exp);
        abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        assert (got == exp) else mismatch(name, got, exp);
    endtask

    // 32-bit fibonacci with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int lane_sample(input logic [`S_AXIS_TDATA_WIDTH-1:0] d, input int lane);
        logic signed [`ADC_RESOLUTION_WIDTH-1:0] s;
        s = d[16*lane +: `ADC_RESOLUTION_WIDTH];
        return int'(s);
    endfunction

    // halving running average of the beat means
    function automatic int reference_baseline();
        int avg;
        int sum;
        avg = 0;
        for (int b = 0; b < init_beats.size(); b++)
        begin
            sum = 0;
            for (int l = 0; l < LANES; l++)
            begin
                sum = sum + lane_sample(init_beats[b], l);
            end
            if (b == 0)
            begin
                avg = sum >>> 3;
            end
            else
            begin
                avg = (avg >>> 1) + ((sum >>> 3) >>> 1);
            end
        end
        return avg;
    endfunction

    // first examined beat above the bound skipping beats sent while pending
    function automatic bit find_expected_hit(input int from, output int idx,
                                             output int peak, output int lane);
        int s;
        idx  = 0;
        peak = 0;
        lane = 0;
        for (int b = from; b < arm_data.size(); b++)
        begin
            if (!arm_pend[b])
            begin
                peak = lane_sample(arm_data[b], 0);
                lane = -1;
                for (int l = 0; l < LANES; l++)
                begin
                    s = lane_sample(arm_data[b], l);
                    if (s > peak)
                    begin
                        peak = s;
                    end
                    if (s > exp_base + MARGIN && lane < 0)
                    begin
                        lane = l;
                    end
                end
                if (lane >= 0)
                begin
                    idx = b;
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    function automatic int probe(input int sel);
        case (sel)
            SIG_DONE:  return int'(calc_complete);
            SIG_STATE: return int'(exec_state);
            default:   return int'(event_req);
        endcase
    endfunction

    task automatic next_edge();
        @(posedge AXIS_ACLK);
        #1;
    endtask

    task automatic idle_cycle();
        next_edge();
        s_axis_tvalid = 1'b0;
    endtask

    task automatic wait_until(input int sel, input int want, input string what);
        int n;
        n = 0;
        while (probe(sel) != want && n < WAIT_LIMIT)
        begin
            idle_cycle();
            n++;
        end
        assert (probe(sel) == want) else abort_run($sformatf("timeout waiting for %s", what));
    endtask

    task automatic drive_lanes(input logic valid);
        for (int i = 0; i < LANES; i++)
        begin
            s_axis_tdata[16*i +: 16] = 16'(lane_val[i]);
        end
        s_axis_tvalid = valid;
    endtask

    // idle cycle now and then with large samples that must be ignored
    task automatic maybe_gap();
        int gap;
        draw_bits(2, gap);
        if (gap == 0)
        begin
            next_edge();
            s_axis_tdata  = {LANES{16'd1800}};
            s_axis_tvalid = 1'b0;
        end
    endtask

    task automatic fill_quiet();
        int r;
        for (int i = 0; i < LANES; i++)
        begin
            draw_bits(6, r);
            lane_val[i] = level + r - 32;
        end
    endtask

    task automatic send_arm_beat(input bit pending);
        maybe_gap();
        next_edge();
        drive_lanes(1'b1);
        arm_data.push_back(s_axis_tdata);
        arm_cyc.push_back(cycle);
        arm_pend.push_back(pending);
    endtask

    task automatic learn_baseline(input int new_level);
        level = new_level;
        init_beats.delete();
        arm_data.delete();
        arm_cyc.delete();
        arm_pend.delete();
        scan_idx = 0;
        while (init_beats.size() < CALC_LEN)
        begin
            fill_quiet();
            maybe_gap();
            next_edge();
            drive_lanes(1'b1);
            init_beats.push_back(s_axis_tdata);
        end
        exp_base = reference_baseline();
        wait_until(SIG_DONE, 1, "calc_complete to rise");
        check_int("baseline", int'(baseline), exp_base);
        wait_until(SIG_STATE, int'(ARMED), "exec_state to reach ARMED");
    endtask

    task automatic build_trigger();
        int lane;
        int lift;
        int coin;
        fill_quiet();
        draw_bits(3, lane);
        draw_bits(8, lift);
        draw_bits(1, coin);
        lane_val[lane] = exp_base + MARGIN + 1 + lift;
        // a larger sample in the top lane makes peak and hit lane differ
        if (coin == 1 && lane < LANES - 1)
        begin
            lane_val[LANES-1] = exp_base + MARGIN + 51 + lift;
        end
    endtask

    task automatic acknowledge_event();
        int extra;
        int ack_hold;
        int l;
        wait_until(SIG_REQ, 1, "event_req to rise");
        draw_bits(2, extra);
        repeat (extra) idle_cycle();
        next_edge();
        s_axis_tvalid = 1'b0;
        event_ack     = 1'b1;
        wait_until(SIG_REQ, 0, "event_req to fall");
        // ack held longer over beats above the bound that must not trigger
        draw_bits(2, ack_hold);
        for (int h = 0; h < ack_hold + 1; h++)
        begin
            fill_quiet();
            draw_bits(3, l);
            lane_val[l] = 1500;
            send_arm_beat(1'b1);
        end
        next_edge();
        s_axis_tvalid = 1'b0;
        event_ack     = 1'b0;
        wait_until(SIG_STATE, int'(ARMED), "exec_state to return to ARMED");
        check_int("event count", events_seen, events_sent);
    endtask

    task automatic run_rounds(input int rounds);
        int quiet;
        int pend;
        int coin;
        int l;
        for (int k = 0; k < rounds; k++)
        begin
            draw_bits(3, quiet);
            for (int q = 0; q < quiet + 2; q++)
            begin
                fill_quiet();
                // exactly on the bound does not trigger
                if (q == 0)
                begin
                    lane_val[0] = exp_base + MARGIN;
                end
                send_arm_beat(1'b0);
            end
            build_trigger();
            send_arm_beat(1'b0);
            events_sent++;
            // beats while the event waits for ack with some above the bound
            draw_bits(3, pend);
            for (int p = 0; p < pend + 3; p++)
            begin
                fill_quiet();
                draw_bits(1, coin);
                draw_bits(3, l);
                if (coin == 1)
                begin
                    lane_val[l] = 1500;
                end
                send_arm_beat(1'b1);
            end
            acknowledge_event();
        end
    endtask

    task automatic pulse_rebase();
        next_edge();
        s_axis_tvalid = 1'b0;
        rebase        = 1'b1;
        next_edge();
        rebase = 1'b0;
        check_int("exec_state", int'(exec_state), int'(INIT));
        wait_until(SIG_DONE, 0, "calc_complete to clear");
    endtask

    task automatic compare_event();
        int  idx;
        int  peak;
        int  lane;
        bit  found;
        found = find_expected_hit(scan_idx, idx, peak, lane);
        assert (found) else abort_run("event_req rose without a beat above the threshold");
        check_int("event_beat", int'(event_beat), idx);
        check_int("event_peak", int'(event_peak), peak);
        check_int("event_lane", int'(event_lane), lane);
        check_int("event_req latency in cycles", cycle - arm_cyc[idx], 2);
        hold_beat = idx;
        hold_peak = peak;
        hold_lane = lane;
        scan_idx  = idx + 1;
        events_seen++;
    endtask

    // handshake and record checks sampled mid-cycle
    always @(negedge AXIS_ACLK)
    begin
        if (AXIS_ARESETN)
        begin
            if (event_req && !req_q)
            begin
                assert (!ack_q) else abort_run("event_req rose before event_ack fell");
                compare_event();
            end
            else if (event_req)
            begin
                check_int("event_beat", int'(event_beat), hold_beat);
                check_int("event_peak", int'(event_peak), hold_peak);
                check_int("event_lane", int'(event_lane), hold_lane);
            end
            if (!event_req && req_q)
            begin
                assert (ack_q) else abort_run("event_req fell before event_ack rose");
            end
            if (req_q && ack_q)
            begin
                assert (!event_req) else abort_run("event_req stayed high after event_ack");
            end
        end
        req_q = event_req;
        ack_q = event_ack;
    end

    initial
    begin
        lfsr          = 32'h123bb8a4;
        AXIS_ARESETN  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        rebase        = 1'b0;
        event_ack     = 1'b0;
        req_q         = 1'b0;
        ack_q         = 1'b0;
        exp_base      = 0;
        scan_idx      = 0;
        events_sent   = 0;
        events_seen   = 0;
        level         = 0;
        repeat (5) @(posedge AXIS_ACLK);
        #1;
        AXIS_ARESETN = 1'b1;
        check_int("event_req", int'(event_req), 0);
        check_int("calc_complete", int'(calc_complete), 0);
        check_int("exec_state", int'(exec_state), int'(INIT));
        check_int("baseline", int'(baseline), 0);

        learn_baseline(100);
        run_rounds(4);

        // relearn at a shifted level
        pulse_rebase();
        learn_baseline(-300);
        run_rounds(3);

        repeat (10) idle_cycle();
        check_int("event count", events_seen, events_sent);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/adc_trig_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_trig_config.svh"

module adc_trig_top
    import adc_trig_pkg::*;
(
    input  logic                                     AXIS_ACLK,
    input  logic                                     AXIS_ARESETN,
    input  logic [`S_AXIS_TDATA_WIDTH-1:0]           s_axis_tdata,
    input  logic                                     s_axis_tvalid,
    input  logic                                     rebase,
    input  logic                                     event_ack,
    output logic signed [`ADC_RESOLUTION_WIDTH-1:0]  baseline,
    output logic                                     calc_complete,
    output exec_state_t                              exec_state,
    output logic                                     event_req,
    output logic [31:0]                              event_beat,
    output logic signed [`ADC_RESOLUTION_WIDTH-1:0]  event_peak,
    output logic [$clog2(`SAMPLES_PER_BEAT)-1:0]     event_lane
);

    logic                                    hit;
    logic signed [`ADC_RESOLUTION_WIDTH-1:0] hit_peak;
    logic [$clog2(`SAMPLES_PER_BEAT)-1:0]    hit_lane;

    // baseline learning in INIT
    base_calc u_base_calc (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .exec_state    (exec_state),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .baseline      (baseline),
        .calc_complete (calc_complete)
    );

    // threshold compare in ARMED
    trigger_detect u_trigger_detect (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .exec_state    (exec_state),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .baseline      (baseline),
        .hit           (hit),
        .hit_peak      (hit_peak),
        .hit_lane      (hit_lane)
    );

    exec_state_ctrl u_exec_state_ctrl (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tvalid (s_axis_tvalid),
        .calc_complete (calc_complete),
        .hit           (hit),
        .hit_peak      (hit_peak),
        .hit_lane      (hit_lane),
        .rebase        (rebase),
        .event_ack     (event_ack),
        .exec_state    (exec_state),
        .event_req     (event_req),
        .event_beat    (event_beat),
        .event_peak    (event_peak),
        .event_lane    (event_lane)
    );

endmodule

`default_nettype wire

// ==== verilog/exec_state_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_trig_config.svh"

module exec_state_ctrl
    import adc_trig_pkg::*;
(
    input  logic                                     AXIS_ACLK,
    input  logic                                     AXIS_ARESETN,
    input  logic                                     s_axis_tvalid,
    input  logic                                     calc_complete,
    input  logic                                     hit,
    input  logic signed [`ADC_RESOLUTION_WIDTH-1:0]  hit_peak,
    input  logic [$clog2(`SAMPLES_PER_BEAT)-1:0]     hit_lane,
    input  logic                                     rebase,
    input  logic                                     event_ack,
    output exec_state_t                              exec_state,
    output logic                                     event_req,
    output logic [31:0]                              event_beat,
    output logic signed [`ADC_RESOLUTION_WIDTH-1:0]  event_peak,
    output logic [$clog2(`SAMPLES_PER_BEAT)-1:0]     event_lane
);

    localparam int BEAT_W = 32;

    logic [BEAT_W-1:0] beat_cnt;
    logic              init_entry;
    logic              arm;
    logic              take_hit;

    // calc_complete is still high from the last run in the first INIT
    // cycle after a rebase, so that cycle must not arm
    assign arm      = (exec_state == INIT) && calc_complete && !init_entry;
    assign take_hit = (exec_state == ARMED) && hit && !rebase;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            exec_state <= INIT;
            event_req  <= 1'b0;
            init_entry <= 1'b0;
        end
        else
        begin
            init_entry <= rebase;
            if (rebase)
            begin
                exec_state <= INIT;
                event_req  <= 1'b0;
            end
            else
            begin
                case (exec_state)
                    INIT:
                    begin
                        if (arm)
                        begin
                            exec_state <= ARMED;
                        end
                    end
                    ARMED:
                    begin
                        if (take_hit)
                        begin
                            exec_state <= TRG;
                            event_req  <= 1'b1;
                        end
                    end
                    TRG:
                    begin
                        // four-phase, drop req on ack then wait for ack low
                        if (event_req && event_ack)
                        begin
                            event_req <= 1'b0;
                        end
                        else if (!event_req && !event_ack)
                        begin
                            exec_state <= ARMED;
                        end
                    end
                    default:
                    begin
                        exec_state <= INIT;
                    end
                endcase
            end
        end
    end

    // beats since arming, still counted while an event is pending
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN || arm)
        begin
            beat_cnt <= '0;
        end
        else if ((exec_state != INIT) && s_axis_tvalid)
        begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // the hit beat was already counted, so its index is one less
    always_ff @(posedge AXIS_ACLK)
    begin
        if (take_hit)
        begin
            event_beat <= beat_cnt - BEAT_W'(1);
            event_peak <= hit_peak;
            event_lane <= hit_lane;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trigger_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_trig_config.svh"

module trigger_detect
    import adc_trig_pkg::*;
(
    input  logic                                     AXIS_ACLK,
    input  logic                                     AXIS_ARESETN,
    input  exec_state_t                              exec_state,
    input  logic [`S_AXIS_TDATA_WIDTH-1:0]           s_axis_tdata,
    input  logic                                     s_axis_tvalid,
    input  logic signed [`ADC_RESOLUTION_WIDTH-1:0]  baseline,
    output logic                                     hit,
    output logic signed [`ADC_RESOLUTION_WIDTH-1:0]  hit_peak,
    output logic [$clog2(`SAMPLES_PER_BEAT)-1:0]     hit_lane
);

    localparam int ADC_W      = `ADC_RESOLUTION_WIDTH;
    localparam int LANES      = `SAMPLES_PER_BEAT;
    localparam int LANE_BITS  = `S_AXIS_TDATA_WIDTH / LANES;
    localparam int LANE_IDX_W = $clog2(LANES);
    // one extra bit so baseline plus margin cannot wrap
    localparam int CMP_W      = ADC_W + 1;

    logic signed [ADC_W-1:0] lane_sample [LANES];
    logic signed [CMP_W-1:0] bound;
    logic [LANES-1:0]        over;
    logic signed [ADC_W-1:0] peak;
    logic [LANE_IDX_W-1:0]   first_lane;

    assign bound = CMP_W'(baseline) + CMP_W'(`THRESHOLD_CODES);

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            lane_sample[i] = s_axis_tdata[LANE_BITS*i +: ADC_W];
            over[i]        = CMP_W'(lane_sample[i]) > bound;
        end
    end

    // beat maximum and lowest exceeding lane in one pass
    always_comb
    begin
        peak       = lane_sample[0];
        first_lane = '0;
        for (int i = LANES - 1; i >= 0; i--)
        begin
            if (lane_sample[i] > peak)
            begin
                peak = lane_sample[i];
            end
            if (over[i])
            begin
                first_lane = LANE_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            hit <= 1'b0;
        end
        else
        begin
            hit <= (exec_state == ARMED) && s_axis_tvalid && (|over);
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (s_axis_tvalid)
        begin
            hit_peak <= peak;
            hit_lane <= first_lane;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/base_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_trig_config.svh"

module base_calc
    import adc_trig_pkg::*;
(
    input  logic                                    AXIS_ACLK,
    input  logic                                    AXIS_ARESETN,
    input  exec_state_t                             exec_state,
    input  logic [`S_AXIS_TDATA_WIDTH-1:0]          s_axis_tdata,
    input  logic                                    s_axis_tvalid,
    output logic signed [`ADC_RESOLUTION_WIDTH-1:0] baseline,
    output logic                                    calc_complete
);

    localparam int ADC_W     = `ADC_RESOLUTION_WIDTH;
    localparam int LANES     = `SAMPLES_PER_BEAT;
    localparam int LANE_BITS = `S_AXIS_TDATA_WIDTH / LANES;
    localparam int LANE_SH   = $clog2(LANES);
    localparam int SUM_W     = ADC_W + LANE_SH;
    localparam int CALC_LEN  = `BASELINE_CALC_LEN;
    localparam int CNT_W     = $clog2(CALC_LEN + 1);

    logic signed [ADC_W-1:0] lane_sample [LANES];
    logic signed [SUM_W-1:0] lane_sum;
    logic signed [SUM_W-1:0] sum_q;
    logic signed [SUM_W-1:0] mean_full;
    logic signed [ADC_W-1:0] beat_mean;
    logic signed [ADC_W-1:0] avg;
    logic [CNT_W-1:0]        acc_cnt;
    logic [CNT_W-1:0]        avg_cnt;
    logic                    sum_vld;
    logic                    avg_last;
    logic                    in_init;
    logic                    in_init_q;
    logic                    accept;

    assign in_init = (exec_state == INIT);
    // stop taking beats once the full set is in the pipe
    assign accept  = in_init && s_axis_tvalid && (acc_cnt < CNT_W'(CALC_LEN));

    // split the beat, the sample sits in the low bits of each lane
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            lane_sample[i] = s_axis_tdata[LANE_BITS*i +: ADC_W];
        end
    end

    always_comb
    begin
        lane_sum = '0;
        for (int i = 0; i < LANES; i++)
        begin
            lane_sum = lane_sum + SUM_W'(lane_sample[i]);
        end
    end

    // beat mean, always fits back into the sample width
    assign mean_full = sum_q >>> LANE_SH;
    assign beat_mean = mean_full[ADC_W-1:0];

    // stage 1 control
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN || !in_init)
        begin
            acc_cnt <= '0;
            sum_vld <= 1'b0;
        end
        else
        begin
            sum_vld <= accept;
            if (accept)
            begin
                acc_cnt <= acc_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (accept)
        begin
            sum_q <= lane_sum;
        end
    end

    // stage 2, halving running average
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN || !in_init)
        begin
            avg_cnt  <= '0;
            avg_last <= 1'b0;
        end
        else
        begin
            avg_last <= sum_vld && (avg_cnt == CNT_W'(CALC_LEN - 1));
            if (sum_vld)
            begin
                avg_cnt <= avg_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (sum_vld)
        begin
            if (avg_cnt == '0)
            begin
                avg <= beat_mean;
            end
            else
            begin
                avg <= (avg >>> 1) + (beat_mean >>> 1);
            end
        end
    end

    // publish, completion drops one cycle after re-entering INIT
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            baseline      <= '0;
            calc_complete <= 1'b0;
            in_init_q     <= 1'b1;
        end
        else
        begin
            in_init_q <= in_init;
            if (in_init && !in_init_q)
            begin
                calc_complete <= 1'b0;
            end
            else if (avg_last)
            begin
                baseline      <= avg;
                calc_complete <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/adc_trig_pkg.sv ====
`default_nettype none

package adc_trig_pkg;

    // channel execution state
    // TRG keeps both bits set so it differs from INIT in every bit
    typedef enum logic [1:0]
    {
        INIT  = 2'b00,
        ARMED = 2'b01,
        TRG   = 2'b11
    } exec_state_t;

endpackage

`default_nettype wire

// ==== verilog/adc_trig_config.svh ====
`ifndef ADC_TRIG_CONFIG_SVH
`define ADC_TRIG_CONFIG_SVH

// converter sample resolution in bits
`define ADC_RESOLUTION_WIDTH 12

// stream beat width, eight 16-bit lanes
`define S_AXIS_TDATA_WIDTH 128

// lanes carried by one beat
`define SAMPLES_PER_BEAT 8

// valid beats averaged while learning the baseline
// 16 keeps simulation short
`define BASELINE_CALC_LEN 16

// trigger margin above baseline in adc codes
// 10 percent of full scale 4096
`define THRESHOLD_CODES 409

`endif
